// ==== Makefile ====
# Verilator flow for the image downscaler

VERILATOR  ?= verilator
TOP        ?= imresize_tb
FILELIST   ?= imresize_top.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall -Wno-fatal
SIM_FLAGS  ?= --assert -Wno-fatal
FAIL_MSG   ?= SOME TESTS FAILED
PASS_MSG   ?= ALL TESTS PASSED

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation gave no result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/imresize_tb.sv ====
// testbench for the image downscaler checking test-list frames against a 2x2 model
`timescale 1ns/1ps

module imresize_tb;

	localparam int READY_TIMEOUT = 5000;   // in cycles, well above one 1024 px pair
	localparam int DRAIN_TIMEOUT = 12000;  // up to two pairs still queued
	localparam int SEED          = 12662;

	logic                       clk;
	logic                       resetn;
	rs_pkg::in_beat_t           in_beat;
	logic                       in_valid;
	logic                       in_ready;
	rs_pkg::resize_mode_e       mode;
	logic [rs_pkg::WIDTH_W-1:0] src_width;
	rs_pkg::out_pix_t           out_pix;
	logic                       out_valid;

	logic [8:0] exp_q [$];   // {data, last} per output pixel
	logic [8:0] exp_pix;     // monitor's current expected pixel
	logic [7:0] img [];      // current frame, row major
	int         frames;
	int         ready_low;   // back-pressure cycles seen in a frame

	imresize_top i_imresize_top (
		.clk         (clk),
		.resetn      (resetn),
		.in_beat_i   (in_beat),
		.in_valid_i  (in_valid),
		.in_ready_o  (in_ready),
		.mode_i      (mode),
		.src_width_i (src_width),
		.out_pix_o   (out_pix),
		.out_valid_o (out_valid)
	);

	always #2 clk = ~clk;  // 4 ns period

	// report why the run stops and end it
	task automatic abort_run(input string why);
	begin
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at %0t", $time);
	end
	endtask

	// compare one value and stop at a mismatch
	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	begin
		if (expected !== actual)
			abort_run($sformatf("[FAIL] time %0t %s expected 0x%0h actual 0x%0h",
				$time, name, expected, actual));
	end
	endtask

	// 0 ramp, 1 random, 2 constant white
	function automatic logic [7:0] pixel_value(input int kind, input int r, input int c);
	begin
		case (kind)
			0:       pixel_value = 8'((c + 2 * r) & 255);  // neighbours differ by 1 and 2
			1:       pixel_value = 8'($urandom_range(255, 0));
			default: pixel_value = 8'hff;                   // widest block sum
		endcase
	end
	endfunction

	// make the frame and queue its expected pixels pair by pair
	task automatic build_frame(input int kind, input int md, input int w, input int rows);
		int         a;
		int         b;
		int         c;
		int         d;
		int         base;
		int         sum;
		logic [7:0] px;
		logic       last_flag;
	begin
		img = new[rows * w];
		for (int r = 0; r < rows; r++)
			for (int col = 0; col < w; col++)
				img[r * w + col] = pixel_value(kind, r, col);
		for (int p = 0; p < rows; p += 2)
		begin
			base = p * w;  // upper row of the pair
			for (int j = 0; j < w / 2; j++)
			begin
				a = int'(img[base + 2 * j]);
				b = int'(img[base + 2 * j + 1]);
				c = int'(img[base + w + 2 * j]);
				d = int'(img[base + w + 2 * j + 1]);
				sum = a + b + c + d;
				if (md == 0)
					px = 8'((sum + 2) / 4);  // mean, halves round up
				else
					px = 8'(a);              // upper-left
				last_flag = (j == w / 2 - 1);
				exp_q.push_back({px, last_flag});
			end
		end
	end
	endtask

	// drive all beats of a frame from one falling edge to the next
	task automatic send_frame(input int w, input int rows, input int stall);
		rs_pkg::in_beat_t beat;
		int               waited;
		int               idx;
	begin
		for (int r = 0; r < rows; r++)
			for (int k = 0; k < w / 4; k++)
			begin
				idx = r * w + 4 * k;
				beat.data = {img[idx + 3], img[idx + 2], img[idx + 1], img[idx]};
				beat.last = (k == w / 4 - 1);  // row end
				if ($urandom_range(99, 0) < stall)
				begin
					in_valid = 1'b0;  // gap of one cycle
					@(negedge clk);
				end
				in_beat  = beat;
				in_valid = 1'b1;
				waited   = 0;
				while (!in_ready)
				begin
					if (waited >= READY_TIMEOUT)
						abort_run("timeout waiting for in_ready to accept a beat");
					waited++;
					ready_low++;
					@(negedge clk);
				end
				@(negedge clk);  // taken on the rising edge in between
			end
		in_valid = 1'b0;
	end
	endtask

	// wait until the monitor has seen every expected pixel
	task automatic wait_drain();
		int waited;
	begin
		waited = 0;
		while (exp_q.size() != 0)
		begin
			if (waited >= DRAIN_TIMEOUT)
				abort_run($sformatf("timeout waiting for %0d outstanding output pixels",
					exp_q.size()));
			waited++;
			@(negedge clk);
		end
	end
	endtask

	// output monitor samples on the falling edge where outputs have settled
	always @(negedge clk)
	begin
		if (resetn && out_valid)
		begin
			if (exp_q.size() == 0)
				abort_run("output pixel strobed while no pixel was expected");
			else
			begin
				exp_pix = exp_q.pop_front();
				check_value("out_pix.data", 32'(exp_pix[8:1]), 32'(out_pix.data));
				check_value("out_pix.last", 32'(exp_pix[0]), 32'(out_pix.last));
			end
		end
	end

	initial
	begin
		int    fd;
		int    md;
		int    w;
		int    rows;
		int    kind;
		int    stall;
		string line;
		clk       = 1'b0;
		resetn    = 1'b0;
		in_beat   = '0;
		in_valid  = 1'b0;
		mode      = rs_pkg::RS_MODE_AVG;
		src_width = rs_pkg::WIDTH_W'(4);
		frames    = 0;
		void'($urandom(SEED));
		repeat (4) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
		check_value("in_ready after reset", 32'd1, 32'(in_ready));
		check_value("out_valid after reset", 32'd0, 32'(out_valid));

		fd = $fopen("dv/imresize_tests.txt", "r");
		if (fd == 0)
			abort_run("could not open the test list dv/imresize_tests.txt");
		while (!$feof(fd))
		begin
			if ($fgets(line, fd) <= 0)
				continue;
			if (line.len() < 2 || line.getc(0) == "#")
				continue;  // comment or blank
			if ($sscanf(line, "%d %d %d %d %d", md, w, rows, kind, stall) != 5)
				abort_run({"malformed line in the test list: ", line});
			if (w < 4 || w > 1024 || w % 4 != 0 || rows < 2 || rows % 2 != 0)
				abort_run({"unsupported frame size in the test list: ", line});
			mode      = rs_pkg::resize_mode_e'(md[0]);  // held for the frame
			src_width = rs_pkg::WIDTH_W'(w);
			ready_low = 0;
			build_frame(kind, md, w, rows);
			send_frame(w, rows, stall);
			wait_drain();
			repeat (4) @(negedge clk);  // engine releases the last pair
			// wide rows without gaps must fill all four rams
			if (stall == 0 && w == 1024 && rows >= 6)
				check_value("in_ready back-pressure seen", 32'd1, 32'(ready_low > 0));
			frames++;
			$display("frame %0d: mode %0d width %0d rows %0d pattern %0d, %0d stall cycles",
				frames, md, w, rows, kind, ready_low);
		end
		$fclose(fd);
		if (frames == 0)
			abort_run("the test list held no frames");
		repeat (20) @(negedge clk);  // a stray strobe would hit the empty queue
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== dv/imresize_tests.txt ====
# mode (0 avg, 1 nearest)  width  rows  pattern (0 ramp, 1 random, 2 const 255)  stall %
# one frame per line, run back to back
0 16 4 0 0
0 64 6 1 20
1 64 4 1 10
0 4 8 1 0
1 4 4 0 30
0 1024 8 0 0
1 1024 6 1 0
0 1024 4 2 15
1 32 2 2 0
0 128 10 1 50
1 128 8 0 5
0 8 2 1 0
1 16 6 1 25
0 64 4 2 0
0 256 8 1 0
1 256 4 0 40
0 20 4 1 10
0 1024 2 1 0
1 8 4 1 0

// ==== hdl/imresize_top.sv ====
// image downscaler top, rows buffer feeding the 2x2 resize engine
`timescale 1ns/1ps

module imresize_top (
	input  logic                       clk,
	input  logic                       resetn,

	// source pixel stream
	input  rs_pkg::in_beat_t           in_beat_i,
	input  logic                       in_valid_i,
	output logic                       in_ready_o,

	// frame config
	input  rs_pkg::resize_mode_e       mode_i,
	input  logic [rs_pkg::WIDTH_W-1:0] src_width_i,

	// scaled pixels out
	output rs_pkg::out_pix_t           out_pix_o,
	output logic                       out_valid_o
);

	rs_pkg::row_rd_t rd_req;        // engine byte reads
	logic            pair_release;
	logic            pair_avail;
	logic [7:0]      row0;          // upper row byte
	logic [7:0]      row1;          // lower row byte

	rows_buffer i_rows_buffer (
		.clk            (clk),
		.resetn         (resetn),
		.beat_i         (in_beat_i),
		.valid_i        (in_valid_i),
		.ready_o        (in_ready_o),
		.rd_req_i       (rd_req),
		.pair_release_i (pair_release),
		.pair_avail_o   (pair_avail),
		.row0_o         (row0),
		.row1_o         (row1)
	);

	resize_engine i_resize_engine (
		.clk            (clk),
		.resetn         (resetn),
		.mode_i         (mode_i),
		.src_width_i    (src_width_i),
		.pair_avail_i   (pair_avail),
		.rd_req_o       (rd_req),
		.pair_release_o (pair_release),
		.row0_i         (row0),
		.row1_i         (row1),
		.pix_o          (out_pix_o),
		.pix_valid_o    (out_valid_o)
	);

endmodule

// ==== hdl/resize_engine.sv ====
// resize engine, walks a row pair by byte address and emits half-width 2x2 results
`timescale 1ns/1ps

module resize_engine (
	input  logic                         clk,
	input  logic                         resetn,

	// frame config, stable per frame
	input  rs_pkg::resize_mode_e         mode_i,
	input  logic [rs_pkg::WIDTH_W-1:0]   src_width_i,  // pixels, multiple of 4

	// rows buffer side
	input  logic                         pair_avail_i,
	output rs_pkg::row_rd_t              rd_req_o,
	output logic                         pair_release_o,
	input  logic [7:0]                   row0_i,       // upper row, 1 cycle after read
	input  logic [7:0]                   row1_i,       // lower row

	// pixel out, no back-pressure
	output rs_pkg::out_pix_t             pix_o,
	output logic                         pix_valid_o
);

	rs_pkg::eng_state_e               state;
	logic [rs_pkg::BYTE_AW-1:0]       rd_addr;      // byte address being read
	logic [rs_pkg::WIDTH_W-1:0]       rd_addr_ext;
	logic [rs_pkg::WIDTH_W-1:0]       last_addr;    // src_width - 1
	logic                             at_last;
	logic                             rd_vld_q;     // row bytes valid this cycle
	logic                             rd_odd_q;     // returned byte is the right column
	logic                             rd_last_q;    // returned byte closes the row
	logic [7:0]                       top0_q;       // left column, upper row
	logic [7:0]                       bot0_q;       // left column, lower row
	logic [9:0]                       blk_sum;
	logic [7:0]                       blk_res;
	logic                             blk_done;

	assign rd_addr_ext = {{(rs_pkg::WIDTH_W - rs_pkg::BYTE_AW){1'b0}}, rd_addr};
	assign last_addr   = src_width_i - 1'b1;
	assign at_last     = (rd_addr_ext == last_addr);

	assign rd_req_o = '{ren: (state == rs_pkg::ENG_READ), raddr: rd_addr};
	assign pair_release_o = (state == rs_pkg::ENG_RELEASE);  // one cycle pulse

	// control fsm
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			state   <= rs_pkg::ENG_IDLE;
			rd_addr <= '0;
		end
		else
		begin
			case (state)
				rs_pkg::ENG_IDLE:
				begin
					rd_addr <= '0;
					if (pair_avail_i)
						state <= rs_pkg::ENG_READ;
				end
				rs_pkg::ENG_READ:
				begin
					rd_addr <= rd_addr + 1'b1;  // one byte per cycle
					if (at_last)
						state <= rs_pkg::ENG_DRAIN;
				end
				rs_pkg::ENG_DRAIN:
				begin
					// hold until the row's last pixel is out
					if (pix_valid_o && pix_o.last)
						state <= rs_pkg::ENG_RELEASE;
				end
				default:
					state <= rs_pkg::ENG_IDLE;  // release done
			endcase
		end
	end

	// read return tracking
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			rd_vld_q <= 1'b0;
		else
			rd_vld_q <= rd_req_o.ren;
	end

	always_ff @(posedge clk)
	begin
		rd_odd_q  <= rd_addr[0];
		rd_last_q <= rd_req_o.ren & at_last;
	end

	// latch left column of the block
	always_ff @(posedge clk)
	begin
		if (rd_vld_q && !rd_odd_q)
		begin
			top0_q <= row0_i;
			bot0_q <= row1_i;
		end
	end

	// 2x2 block, right column straight from the buffer
	assign blk_done = rd_vld_q & rd_odd_q;
	assign blk_sum  = {2'b00, top0_q} + {2'b00, bot0_q}
		+ {2'b00, row0_i} + {2'b00, row1_i} + 10'd2;  // +2 rounds to nearest
	assign blk_res  = (mode_i == rs_pkg::RS_MODE_AVG) ? blk_sum[9:2] : top0_q;

	// output register
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			pix_valid_o <= 1'b0;
		else
			pix_valid_o <= blk_done;
	end

	always_ff @(posedge clk)
	begin
		if (blk_done)
		begin
			pix_o.data <= blk_res;
			pix_o.last <= rd_last_q;  // pixel src_width/2-1
		end
	end

	a_idle_quiet: assert property (@(posedge clk) disable iff (!resetn)
		pix_valid_o |-> (state != rs_pkg::ENG_IDLE))
		else $error("pixel strobe while engine idle");

	a_width_ok: assert property (@(posedge clk) disable iff (!resetn)
		(state == rs_pkg::ENG_IDLE && pair_avail_i)
		|-> (src_width_i != '0 && src_width_i[1:0] == 2'b00
			&& src_width_i <= (1 << rs_pkg::BYTE_AW)))
		else $error("source width not a nonzero multiple of 4 up to 1024");

endmodule

// ==== hdl/rows_buffer.sv ====
// ping-pong line buffer, takes rows from the input stream and serves them as row pairs
`timescale 1ns/1ps

module rows_buffer (
	input  logic             clk,
	input  logic             resetn,

	// pixel stream in
	input  rs_pkg::in_beat_t beat_i,
	input  logic             valid_i,
	output logic             ready_o,

	// row pair side
	input  rs_pkg::row_rd_t  rd_req_i,
	input  logic             pair_release_i,
	output logic             pair_avail_o,
	output logic [7:0]       row0_o,     // upper row byte
	output logic [7:0]       row1_o      // lower row byte
);

	logic [2:0]                  row_cnt;    // rows held, 0..4
	logic [3:0]                  wptr;       // one-hot target ram
	logic                        rptr;       // 0 -> rams 0/1, 1 -> rams 2/3
	logic                        rptr_q;     // pointer seen by the read data
	logic [rs_pkg::BUF_AW-1:0]   waddr;      // word in the row being written
	logic [rs_pkg::BUF_AW-1:0]   rd_word;
	logic [$clog2(rs_pkg::BYTES_PER_BEAT)-1:0] rd_lane;
	logic [$clog2(rs_pkg::BYTES_PER_BEAT)-1:0] lane_q;  // lane for the output mux
	logic                        wr_fire;
	logic                        row_commit;
	logic                        pair_take;
	logic                        rd_fire;
	logic [3:0]                  ram_wen;
	logic [3:0]                  ram_ren;
	logic [rs_pkg::STREAM_W-1:0] ram_dout [4];
	logic [rs_pkg::STREAM_W-1:0] upper_word;
	logic [rs_pkg::STREAM_W-1:0] lower_word;

	assign ready_o      = ~row_cnt[2];              // below four rows
	assign pair_avail_o = row_cnt[2] | row_cnt[1];  // two or more rows

	assign wr_fire    = valid_i & ready_o;
	assign row_commit = wr_fire & beat_i.last;
	assign pair_take  = pair_release_i & pair_avail_o;
	assign rd_fire    = rd_req_i.ren & pair_avail_o;

	// byte address -> ram word and lane within the beat
	assign rd_word = rd_req_i.raddr[rs_pkg::BYTE_AW-1:$clog2(rs_pkg::BYTES_PER_BEAT)];
	assign rd_lane = rd_req_i.raddr[$clog2(rs_pkg::BYTES_PER_BEAT)-1:0];

	// row count, a commit adds one and a release takes two
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			row_cnt <= 3'd0;
		else
		begin
			case ({row_commit, pair_take})
				2'b10:   row_cnt <= row_cnt + 3'd1;
				2'b01:   row_cnt <= row_cnt - 3'd2;
				2'b11:   row_cnt <= row_cnt - 3'd1;  // both in one cycle
				default: row_cnt <= row_cnt;
			endcase
		end
	end

	// write side pointers
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			wptr  <= 4'b0001;
			waddr <= '0;
		end
		else if (wr_fire)
		begin
			if (beat_i.last)
			begin
				wptr  <= {wptr[2:0], wptr[3]};  // next ram in turn
				waddr <= '0;                    // new row starts at word 0
			end
			else
				waddr <= waddr + 1'b1;
		end
	end

	// read pair pointer, flips per consumed pair
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			rptr <= 1'b0;
		else if (pair_take)
			rptr <= ~rptr;
	end

	// lane and pair follow the ram read by one cycle
	always_ff @(posedge clk)
	begin
		if (rd_fire)
		begin
			lane_q <= rd_lane;
			rptr_q <= rptr;
		end
	end

	assign ram_wen = {4{wr_fire}} & wptr;
	assign ram_ren = {4{rd_fire}} & {{2{rptr}}, {2{~rptr}}};

	for (genvar g = 0; g < 4; g++)
	begin : g_ram
		sdp_ram #(
			.DATA_W (rs_pkg::STREAM_W),
			.DEPTH  (rs_pkg::BUF_DEPTH)
		) i_sdp_ram (
			.clk     (clk),
			.wen_i   (ram_wen[g]),
			.waddr_i (waddr),
			.wdata_i (beat_i.data),
			.ren_i   (ram_ren[g]),
			.raddr_i (rd_word),
			.rdata_o (ram_dout[g])
		);
	end

	// even ram holds the upper row of a pair, odd ram the lower
	assign upper_word = rptr_q ? ram_dout[2] : ram_dout[0];
	assign lower_word = rptr_q ? ram_dout[3] : ram_dout[1];
	assign row0_o = upper_word[{lane_q, 3'b000} +: 8];  // byte k is pixel 4w+k
	assign row1_o = lower_word[{lane_q, 3'b000} +: 8];

	a_cnt_max: assert property (@(posedge clk) disable iff (!resetn)
		row_cnt <= 3'd4)
		else $error("rows buffer holds more than four rows");

	a_release_pair: assert property (@(posedge clk) disable iff (!resetn)
		pair_release_i |-> pair_avail_o)
		else $error("pair released with no pair stored");

	a_read_pair: assert property (@(posedge clk) disable iff (!resetn)
		rd_req_i.ren |-> pair_avail_o)
		else $error("row read with no pair stored");

endmodule

// ==== hdl/rs_pkg.sv ====
// shared constants, bus structs and enums for the image downscaler
package rs_pkg;

	// input stream geometry
	localparam int STREAM_W       = 32;  // beat width
	localparam int BYTES_PER_BEAT = 4;   // one gray pixel per byte

	// row storage
	localparam int BUF_DEPTH = 256;  // words per row ram, 1024 pixels
	localparam int BUF_AW    = 8;    // word address
	localparam int BYTE_AW   = 10;   // byte address on the read side
	localparam int WIDTH_W   = 11;   // source width field, up to 1024

	// input beat, last flags the row end
	typedef struct packed {
		logic [STREAM_W-1:0] data;
		logic                last;
	} in_beat_t;

	// output pixel, last flags final pixel of an output row
	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} out_pix_t;

	// row pair read request, one byte address per cycle
	typedef struct packed {
		logic               ren;
		logic [BYTE_AW-1:0] raddr;
	} row_rd_t;

	typedef enum logic {
		RS_MODE_AVG,      // rounded 2x2 mean
		RS_MODE_NEAREST   // upper-left pixel
	} resize_mode_e;

	typedef enum logic [1:0] {
		ENG_IDLE,
		ENG_READ,
		ENG_DRAIN,
		ENG_RELEASE
	} eng_state_e;

endpackage

// ==== hdl/sdp_ram.sv ====
// simple dual-port ram, one write port and one registered read port
`timescale 1ns/1ps

module sdp_ram #(
	parameter int DATA_W = 32,
	parameter int DEPTH  = 256
)(
	input  logic                     clk,

	// write port
	input  logic                     wen_i,
	input  logic [$clog2(DEPTH)-1:0] waddr_i,
	input  logic [DATA_W-1:0]        wdata_i,

	// read port, data one cycle after ren
	input  logic                     ren_i,
	input  logic [$clog2(DEPTH)-1:0] raddr_i,
	output logic [DATA_W-1:0]        rdata_o
);

	logic [DATA_W-1:0] mem [DEPTH];  // storage array

	// write side
	always_ff @(posedge clk)
	begin
		if (wen_i)
			mem[waddr_i] <= wdata_i;
	end

	// read side, old data on a same-address collision
	always_ff @(posedge clk)
	begin
		if (ren_i)
			rdata_o <= mem[raddr_i];  // holds when not read
	end

endmodule

// ==== imresize_top.f ====
hdl/rs_pkg.sv
hdl/sdp_ram.sv
hdl/rows_buffer.sv
hdl/resize_engine.sv
hdl/imresize_top.sv
dv/imresize_tb.sv
